// File: files.f
logic/fe_cfg_pkg.sv
logic/fe_types_pkg.sv
logic/fe_lane_if.sv
logic/fetch_sequencer.sv
logic/stall_replay_buffer.sv
logic/issue_latch.sv
logic/fetch_frontend.sv
verification/fetch_frontend_props.sv
verification/fetch_frontend_tb.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= fetch_frontend_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	grep -q "^Test OK$$" $(LOG) || exit 1; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/fetch_frontend_tb.sv
// ---------------------------------------------------------------------------
// fetch front end testbench
// memory model, table of stall and redirect scenarios, and an in-order
// checker of every issued bundle against the memory contents
// ---------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fetch_frontend_tb;
  import fe_cfg_pkg::*;
  import fe_types_pkg::*;

  localparam int lanes = 4;
  localparam logic [31:0] seed = 32'h74a486a4;
  localparam int busy_period = 6;  // cycles per fixed busy pattern

  typedef struct {
    string       name;
    logic [15:0] start;
    int          mode;       // 0 none, 1 fixed pattern, 2 random
    int          stall_len;  // busy cycles per pattern period
    int          redir_at;   // bundles before a second redirect, 0 for none
    int          count;
  } row_t;

  logic clk = 1'b0;
  logic rst;
  logic [addr_w-1:0] imem_addr;
  logic [lanes*word_w-1:0] imem_data = '0;
  logic backend_busy = 1'b0;
  logic redirect;
  logic [addr_w-1:0] redirect_pc;
  logic issue_valid;
  logic [lanes*word_w-1:0] issue_words;
  op_class_e issue_ops [lanes];

  row_t rows [8];
  int cur_mode = 0;
  int cur_len = 0;
  int cyc = 0;
  logic [31:0] rnd = seed;
  logic rnd_bit;
  int errors = 0;
  int bundles_seen = 0;
  int total_bundles = 0;
  logic [15:0] exp_addr = '0;
  logic tol = 1'b0;
  logic busy_prev = 1'b1;
  int post_rst = 0;
  logic timed_out = 1'b0;

  fetch_frontend #(.lanes(lanes)) u_fetch_frontend (
    .clk, .rst, .imem_addr, .imem_data, .backend_busy, .redirect,
    .redirect_pc, .issue_valid, .issue_words, .issue_ops
  );

  always #5 clk = ~clk;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // low half is the address, top two bits are the opcode class
  function automatic logic [31:0] model_word(input logic [15:0] a);
    logic [31:0] s;
    logic [1:0]  top;
    s = seed ^ {16'h0, a};
    s = lfsr_next(s);
    top[1] = s[0];
    s = lfsr_next(s);
    top[0] = s[0];
    return {top, s[15:2], a};
  endfunction

  function automatic op_class_e class_of(input logic [1:0] top);
    case (top)
      2'd0:    return alu;
      2'd1:    return load;
      2'd2:    return store;
      default: return branch;
    endcase
  endfunction

  always @(posedge clk) begin
    for (int k = 0; k < lanes; k++) begin
      imem_data[k*word_w +: word_w] <= (^imem_addr === 1'bx) ? 32'h0 :
                                       model_word(imem_addr + 16'(k));
    end
  end

  // busy level per row mode
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cur_mode == 1) begin
      backend_busy <= (cyc % busy_period) < cur_len;
    end else if (cur_mode == 2) begin
      rnd = lfsr_next(rnd);
      rnd_bit = rnd[0];
      rnd = lfsr_next(rnd);
      backend_busy <= rnd_bit & rnd[0];
    end else begin
      backend_busy <= 1'b0;
    end
  end

  task automatic check_bundle(input string name);
    logic [31:0] exp_w;
    logic [31:0] act_w;
    if (tol && issue_words[15:0] != exp_addr) begin
      tol = 1'b0;  // old bundle captured before the flush
      return;
    end
    for (int k = 0; k < lanes; k++) begin
      exp_w = model_word(exp_addr + 16'(k));
      act_w = issue_words[k*word_w +: word_w];
      assert (act_w == exp_w) else begin
        $display("MISMATCH %s lane %0d word expected %h actual %h", name, k, exp_w, act_w);
        errors++;
      end
      assert (issue_ops[k] == class_of(exp_w[31:30])) else begin
        $display("MISMATCH %s lane %0d op expected %0d actual %0d", name, k,
                 class_of(exp_w[31:30]), issue_ops[k]);
        errors++;
      end
    end
    exp_addr = exp_addr + 16'(lanes);  // next bundle in address order
    bundles_seen++;
    total_bundles++;
  endtask

  string cur_name = "reset";

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst) begin
      post_rst = 0;
      assert (!issue_valid) else begin
        $display("issue_valid high during reset");
        errors++;
      end
    end else begin
      if (post_rst < 3) begin
        assert (!issue_valid) else begin
          $display("issue_valid high before the first bundle was fetched");
          errors++;
        end
        post_rst++;
      end
      if (!busy_prev && issue_valid) check_bundle(cur_name);
      tol = 1'b0;
      if (redirect) begin
        exp_addr = redirect_pc;
        tol = 1'b1;
      end
    end
    busy_prev = backend_busy;
  end

  initial begin
    int limit;
    int n;
    logic redir_done;
    rows[0] = '{"stream",       16'h0100, 0, 0, 0, 12};
    rows[1] = '{"stall_one",    16'h0200, 1, 1, 0, 16};
    rows[2] = '{"stall_two",    16'h0300, 1, 2, 0, 16};
    rows[3] = '{"stall_three",  16'h0400, 1, 3, 0, 16};
    rows[4] = '{"random_busy",  16'h0500, 2, 0, 0, 60};
    rows[5] = '{"redir_mid",    16'h0600, 0, 0, 5, 14};
    rows[6] = '{"redir_stall",  16'h0700, 1, 3, 6, 16};
    rows[7] = '{"random_redir", 16'h1f00, 2, 0, 20, 40};
    rst = 1'b1;
    redirect = 1'b0;
    redirect_pc = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    repeat (20) @(posedge clk);  // stream from address zero
    for (int r = 0; r < 8 && !timed_out; r++) begin
      cur_name = rows[r].name;
      cur_mode <= rows[r].mode;
      cur_len <= rows[r].stall_len;
      redirect <= 1'b1;
      redirect_pc <= rows[r].start;
      @(posedge clk);
      redirect <= 1'b0;
      bundles_seen = 0;
      redir_done = 1'b0;
      limit = rows[r].count * 30 + 100;
      n = 0;
      while (bundles_seen < rows[r].count && n < limit) begin
        // a fixed pattern row redirects inside a busy window
        if (!redir_done && rows[r].redir_at > 0 && bundles_seen >= rows[r].redir_at &&
            (rows[r].mode != 1 || (cyc % busy_period) < cur_len)) begin
          redirect <= 1'b1;
          redirect_pc <= rows[r].start + 16'h0800;
          redir_done = 1'b1;
        end else begin
          redirect <= 1'b0;
        end
        @(posedge clk);
        n++;
      end
      redirect <= 1'b0;
      if (n >= limit) begin
        $display("timeout waiting for bundles in row %s", rows[r].name);
        errors++;
        timed_out = 1'b1;
      end
    end
    cur_mode <= 0;
    repeat (10) @(posedge clk);
    $display("errors %0d bundles checked %0d", errors, total_bundles);
    if (errors == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/fetch_frontend_props.sv
// ---------------------------------------------------------------------------
// issue side properties
// reset value, hold under back end stall and known valid on the issue
// latch outputs
// ---------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fetch_frontend_props #(
  parameter int words_w = 128
) (
  input wire logic               clk,
  input wire logic               rst,
  input wire logic               backend_busy,
  input wire logic               issue_valid,
  input wire logic [words_w-1:0] issue_words
);

  // the first bundle needs four cycles to reach the issue latch
  valid_low_after_reset: assert property (
    @(posedge clk) $fell(rst) |-> !issue_valid ##1 !issue_valid ##1 !issue_valid
      ##1 !issue_valid
  ) else $error("issue_valid went high before the first bundle could reach issue");

  // busy freezes the issued bundle
  hold_while_busy: assert property (
    @(posedge clk) disable iff (rst)
    backend_busy |=> ($stable(issue_valid) && $stable(issue_words))
  ) else $error("issue outputs changed while backend_busy was high");

  valid_known: assert property (
    @(posedge clk) disable iff (rst) !$isunknown(issue_valid)
  ) else $error("issue_valid is unknown");

endmodule

bind issue_latch fetch_frontend_props #(.words_w(lanes*word_w)) u_fetch_frontend_props (
  .clk          (clk),
  .rst          (rst),
  .backend_busy (backend_busy),
  .issue_valid  (issue_valid),
  .issue_words  (issue_words)
);

`default_nettype wire

// File: logic/fetch_frontend.sv
// ---------------------------------------------------------------------------
// fetch front end top
// sequencer, one stall replay buffer per fetch slot and the issue latch.
// address out at t, memory data back at t+1, bundle issued at t+4 when
// the back end is free
// ---------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fetch_frontend
  import fe_cfg_pkg::*;
  import fe_types_pkg::*;
#(
  parameter int lanes = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  output logic [addr_w-1:0]       imem_addr,
  input  logic [lanes*word_w-1:0] imem_data,
  input  logic                    backend_busy,
  input  logic                    redirect,
  input  logic [addr_w-1:0]       redirect_pc,
  output logic                    issue_valid,
  output logic [lanes*word_w-1:0] issue_words,
  output op_class_e               issue_ops [lanes]
);

  localparam int width = word_w + 1;  // word plus valid

  fe_lane_if #(.width(width)) lane_bus [lanes] ();

  fetch_sequencer #(.lanes(lanes)) u_fetch_sequencer (
    .clk         (clk),
    .rst         (rst),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .lane        (lane_bus)
  );

  for (genvar i = 0; i < lanes; i++) begin : g_lane
    assign lane_bus[i].except = redirect;  // flush every slot

    stall_replay_buffer #(.width(width)) u_stall_replay_buffer (
      .clk  (clk),
      .rst  (rst),
      .lane (lane_bus[i])
    );
  end

  issue_latch #(.lanes(lanes)) u_issue_latch (
    .clk          (clk),
    .rst          (rst),
    .lane         (lane_bus),
    .backend_busy (backend_busy),
    .issue_valid  (issue_valid),
    .issue_words  (issue_words),
    .issue_ops    (issue_ops)
  );

endmodule

`default_nettype wire

// File: logic/issue_latch.sv
// ---------------------------------------------------------------------------
// issue latch
// takes the lane outputs as one issued bundle whenever the back end is
// free and holds it otherwise. each word gets its opcode class from its
// top two bits. also hands the busy level to every lane as its stall
// ---------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module issue_latch
  import fe_cfg_pkg::*;
  import fe_types_pkg::*;
#(
  parameter int lanes = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  fe_lane_if.sink                 lane [lanes],
  input  logic                    backend_busy,
  output logic                    issue_valid,
  output logic [lanes*word_w-1:0] issue_words,
  output op_class_e               issue_ops [lanes]
);

  logic [word_w:0] lane_rd [lanes];  // {valid, word} per slot

  function automatic op_class_e classify(input logic [1:0] top);
    op_class_e cls;
    case (top)
      2'b00:   cls = alu;
      2'b01:   cls = load;
      2'b10:   cls = store;
      default: cls = branch;
    endcase
    return cls;
  endfunction

  for (genvar i = 0; i < lanes; i++) begin : g_lane
    assign lane[i].fstall = backend_busy;
    assign lane_rd[i]     = lane[i].read_data;
  end

  // lanes move in lockstep, so lane 0 speaks for the bundle
  always_ff @(posedge clk) begin
    if (rst) begin
      issue_valid <= 1'b0;
    end else if (!backend_busy) begin
      issue_valid <= lane_rd[0][word_w];
    end
  end

  always_ff @(posedge clk) begin
    if (!backend_busy) begin
      for (int i = 0; i < lanes; i++) begin
        issue_words[i*word_w +: word_w] <= lane_rd[i][word_w-1:0];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < lanes; i++) begin
      issue_ops[i] = classify(issue_words[i*word_w + word_w - 2 +: 2]);
    end
  end

endmodule

`default_nettype wire

// File: logic/stall_replay_buffer.sv
// ---------------------------------------------------------------------------
// stall replay buffer
// one per fetch slot. the source keeps sending two bundles after the stall
// rises; two capture registers take them, tagged by one-hot trackers with
// the stall cycle they arrived on. after release both are replayed in
// order ahead of the normal registered path. the output holds while
// stalled, and a flush drops everything captured
// ---------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module stall_replay_buffer #(
  parameter int width = 33
) (
  input logic       clk,
  input logic       rst,
  fe_lane_if.buffer lane
);

  localparam logic [2:0] at_start = 3'b001;
  localparam logic [2:0] at_one   = 3'b010;
  localparam logic [2:0] at_two   = 3'b100;

  logic [2:0]       pos_first;   // tracks cap_first, older skid bundle
  logic [2:0]       pos_second;  // tracks cap_second, counts stall cycles
  logic [width-1:0] cap_first;
  logic [width-1:0] cap_second;
  logic [width-1:0] replay_q;
  logic [width-1:0] pass_q;      // normal registered input
  logic             use_replay;

  assign lane.read_data = use_replay ? replay_q : pass_q;

  always_ff @(posedge clk) begin
    if (rst || lane.except) begin
      pos_first         <= at_one;
      pos_second        <= at_start;
      use_replay        <= 1'b0;
      pass_q[width-1]   <= 1'b0;  // output valid drops
    end else if (lane.fstall) begin
      if (!pos_first[2])  pos_first  <= pos_first << 1;
      if (!pos_second[2]) pos_second <= pos_second << 1;
      if (pos_first[1])   cap_first  <= lane.write_data;  // first stall cycle
      if (pos_second[1])  cap_second <= lane.write_data;  // second stall cycle
    end else begin
      replay_q   <= cap_first;
      use_replay <= pos_first[2];
      pos_second <= at_start;
      if (pos_second[2]) begin
        cap_first <= cap_second;      // second skid bundle moves up
        pos_first <= at_two;
      end else if (pos_second[1]) begin
        cap_first <= lane.write_data;  // one-cycle stall, last skid arrives now
        pos_first <= at_two;
      end else begin
        pos_first <= at_one;
      end
      if (lane.en) begin
        pass_q <= lane.write_data;
      end else begin
        pass_q[width-1] <= 1'b0;  // empty slot
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/fetch_sequencer.sv
// ---------------------------------------------------------------------------
// fetch sequencer
// keeps the program counter, requests one bundle per cycle from the
// instruction memory and spreads the returned words over the lanes.
// the valid of a request trails the stall level by skid_depth cycles, so
// the lanes see the stall late. a redirect reloads the pc and drops every
// return still in flight
// ---------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fetch_sequencer
  import fe_cfg_pkg::*;
  import fe_types_pkg::*;
#(
  parameter int lanes = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  output logic [addr_w-1:0]       imem_addr,
  input  logic [lanes*word_w-1:0] imem_data,
  input  logic                    redirect,
  input  logic [addr_w-1:0]       redirect_pc,
  fe_lane_if.source               lane [lanes]
);

  seq_state_e              state;
  logic [addr_w-1:0]       pc;
  logic                    stall;
  logic                    take;
  logic                    flush;
  logic [skid_depth-1:0]   vld_pipe;  // [0] request in memory, [1] word on lanes
  logic [lanes*word_w-1:0] ret_q;

  assign stall     = lane[0].fstall;  // every lane carries the same level
  assign take      = !stall;          // address of this cycle is accepted
  assign imem_addr = pc;

  // the return of the redirect cycle's own request is still one stage back,
  // so it gets dropped while in the redirecting state
  assign flush = redirect || (state == redirecting);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fetching;
    end else if (redirect) begin
      state <= redirecting;
    end else if (stall) begin
      state <= holding;
    end else begin
      state <= fetching;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (take) begin
      pc <= pc + addr_w'(lanes);  // next bundle
    end
  end

  // two skid bundles fall out of this pipe after the stall rises
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[0] && !flush, take};
    end
  end

  always_ff @(posedge clk) begin
    ret_q <= imem_data;  // word k of the bundle sits at pc + k
  end

  for (genvar i = 0; i < lanes; i++) begin : g_lane
    assign lane[i].write_data = {vld_pipe[skid_depth-1], ret_q[i*word_w +: word_w]};
    assign lane[i].en         = vld_pipe[skid_depth-1];
  end

endmodule

`default_nettype wire

// File: logic/fe_lane_if.sv
// ---------------------------------------------------------------------------
// fetch lane interface
// one fetch slot from the sequencer through its replay buffer to the issue
// latch; the word payload carries its valid bit in the msb
// ---------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface fe_lane_if
  import fe_cfg_pkg::*;
#(
  parameter int width = word_w + 1
) ();

  logic [width-1:0] write_data;  // {valid, word} from the sequencer
  logic             en;          // write_data holds a new word
  logic [width-1:0] read_data;   // {valid, word} toward issue
  logic             fstall;      // back end busy level
  logic             except;      // redirect flush

  modport source (output write_data, output en, input fstall);

  modport buffer (input write_data, input en, input fstall, input except,
                  output read_data);

  modport sink (input read_data, output fstall);

endinterface

`default_nettype wire

// File: logic/fe_types_pkg.sv
// ---------------------------------------------------------------------------
// fetch front end types
// sequencer states and the two-bit opcode class taken from the top of
// each instruction word
// ---------------------------------------------------------------------------
`default_nettype none

package fe_types_pkg;

  typedef enum logic [1:0] {
    fetching    = 2'd0,  // pc advances every cycle
    holding     = 2'd1,  // back end busy, pc frozen
    redirecting = 2'd2   // first cycle after a redirect
  } seq_state_e;

  // encoding equals word[31:30]
  typedef enum logic [1:0] {
    alu    = 2'd0,
    load   = 2'd1,
    store  = 2'd2,
    branch = 2'd3
  } op_class_e;

endpackage

`default_nettype wire

// File: logic/fe_cfg_pkg.sv
// ---------------------------------------------------------------------------
// fetch front end sizing
// word, address and skid dimensions shared by the sequencer, the lane
// buffers and the issue latch
// ---------------------------------------------------------------------------
`default_nettype none

package fe_cfg_pkg;

  // one instruction word
  localparam int word_w = 32;

  // word address carried on imem_addr and redirect_pc
  localparam int addr_w = 16;

  // The back end stall reaches the fetch source this many cycles late.
  // After the stall rises the source still hands over this many bundles,
  // and after it falls the same number of empty slots follow before the
  // new stream arrives. The lane buffer holds exactly two capture
  // registers for this, so the value is tied to its shape.
  localparam int skid_depth = 2;

endpackage

`default_nettype wire
